/* hdl/dccm_pkg.sv */
`default_nettype none

package dccm_pkg;

   localparam int DCCM_BITS   = 12;                               // 4 KiB byte address
   localparam int DATA_WIDTH  = 32;
   localparam int BYTE_WIDTH  = 4;
   localparam int OFFSET_BITS = 2;
   localparam int BANK_BITS   = 1;                                // addr bit 2 picks the bank
   localparam int ROW_BITS    = DCCM_BITS - OFFSET_BITS - BANK_BITS;

   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_e;

   typedef struct packed {
      logic [ROW_BITS-1:0]    row;
      logic [BANK_BITS-1:0]   bank;
      logic [OFFSET_BITS-1:0] offset;
   } dccm_addr_fields_t;

   // same address bits, seen flat for arithmetic or split for bank decode
   typedef union packed {
      logic [DCCM_BITS-1:0] flat;
      dccm_addr_fields_t    fields;
   } dccm_addr_u;

   typedef struct packed {
      logic                  valid;
      logic                  load;
      logic                  store;
      access_size_e          size;
      dccm_addr_u            addr;
      logic [DATA_WIDTH-1:0] data;                                 // store data, right-justified
   } lsu_pkt_t;

   typedef struct packed {
      dccm_addr_u            addr;                                 // word aligned
      logic [DATA_WIDTH-1:0] data;
   } stbuf_req_t;

   typedef struct packed {
      logic                  rden;
      dccm_addr_u            rd_addr_lo;                           // start address
      dccm_addr_u            rd_addr_hi;                           // end address
      logic                  wren;
      dccm_addr_u            wr_addr;
      logic [DATA_WIDTH-1:0] wr_data;
   } mem_req_t;

   typedef struct packed {
      logic                    valid;
      logic                    load;
      logic                    store;
      logic                    dual;                               // access spans two words
      logic [OFFSET_BITS-1:0]  offset;
      logic [2*BYTE_WIDTH-1:0] byteen;                             // byte enable over hi:lo words
      logic [DATA_WIDTH-1:0]   store_data;
   } pipe_m_t;

endpackage

`default_nettype wire

/* hdl/lsu_dccm_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_dccm_decode (
   input  logic               clk,
   input  logic               rst,
   input  dccm_pkg::lsu_pkt_t lsu_pkt,
   output dccm_pkg::mem_req_t rd_req,
   output dccm_pkg::pipe_m_t  pipe_m
);
   import dccm_pkg::*;

   dccm_addr_u             start_addr;
   dccm_addr_u             end_addr;
   logic [OFFSET_BITS-1:0] len_m1;                                 // access length minus one
   logic [BYTE_WIDTH-1:0]  size_byteen;
   logic                   dual;
   logic                   aligned_word;
   logic                   rden;
   pipe_m_t                pipe_m_d;

   assign start_addr = lsu_pkt.addr;

   always_comb begin
      case (lsu_pkt.size)
         size_half: begin
            len_m1      = 2'd1;
            size_byteen = 4'b0011;
         end
         size_word: begin
            len_m1      = 2'd3;
            size_byteen = 4'b1111;
         end
         default: begin                                            // byte
            len_m1      = 2'd0;
            size_byteen = 4'b0001;
         end
      endcase
   end

   assign end_addr.flat = start_addr.flat + DCCM_BITS'(len_m1);

   // end lands in the next word, so both banks are read
   assign dual = end_addr.flat[DCCM_BITS-1:OFFSET_BITS] !=
                 start_addr.flat[DCCM_BITS-1:OFFSET_BITS];

   assign aligned_word = (lsu_pkt.size == size_word) & (start_addr.fields.offset == '0);

   // an aligned word store overwrites the whole word, no old data needed
   assign rden = lsu_pkt.valid & (lsu_pkt.load | (lsu_pkt.store & ~aligned_word));

   always_comb begin
      rd_req            = '0;                                      // write side belongs to the arbiter
      rd_req.rden       = rden;
      rd_req.rd_addr_lo = start_addr;
      rd_req.rd_addr_hi = end_addr;
   end

   always_comb begin
      pipe_m_d.valid      = lsu_pkt.valid;
      pipe_m_d.load       = lsu_pkt.load;
      pipe_m_d.store      = lsu_pkt.store;
      pipe_m_d.dual       = dual;
      pipe_m_d.offset     = start_addr.fields.offset;
      pipe_m_d.byteen     = {{BYTE_WIDTH{1'b0}}, size_byteen} << start_addr.fields.offset;
      pipe_m_d.store_data = lsu_pkt.data;
   end

   // D to M pipe register, only valid is cleared
   always_ff @(posedge clk) begin
      pipe_m <= pipe_m_d;
      if (rst) begin
         pipe_m.valid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* hdl/lsu_dccm_port_arb.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_dccm_port_arb (
   input  dccm_pkg::mem_req_t   rd_req,
   input  logic                 stbuf_valid,
   input  dccm_pkg::stbuf_req_t stbuf_req,
   output logic                 stbuf_ready,
   output dccm_pkg::mem_req_t   mem_req
);
   import dccm_pkg::*;

   logic [BANK_BITS-1:0] stbuf_bank;
   logic                 bank_conflict;

   assign stbuf_bank = stbuf_req.addr.fields.bank;

   // a D-stage read owns the banks it touches this cycle
   assign bank_conflict = rd_req.rden &
                          ((stbuf_bank == rd_req.rd_addr_lo.fields.bank) |
                           (stbuf_bank == rd_req.rd_addr_hi.fields.bank));

   assign stbuf_ready = ~bank_conflict;

   always_comb begin
      mem_req.rden       = rd_req.rden;
      mem_req.rd_addr_lo = rd_req.rd_addr_lo;
      mem_req.rd_addr_hi = rd_req.rd_addr_hi;
      mem_req.wren       = stbuf_valid & stbuf_ready;              // write in the accepting cycle
      mem_req.wr_addr    = stbuf_req.addr;
      mem_req.wr_data    = stbuf_req.data;
   end

endmodule

`default_nettype wire

/* hdl/lsu_dccm_result.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_dccm_result (
   input  logic                              clk,
   input  logic                              rst,
   input  dccm_pkg::pipe_m_t                 pipe_m,
   input  logic [dccm_pkg::DATA_WIDTH-1:0]   mem_rd_data_lo,
   input  logic [dccm_pkg::DATA_WIDTH-1:0]   mem_rd_data_hi,
   input  logic [2*dccm_pkg::DATA_WIDTH-1:0] stbuf_fwd_data,
   input  logic [2*dccm_pkg::BYTE_WIDTH-1:0] stbuf_fwd_byteen,
   output logic                              ld_valid,
   output logic [dccm_pkg::DATA_WIDTH-1:0]   ld_data,
   output logic                              st_valid,
   output logic [dccm_pkg::DATA_WIDTH-1:0]   st_data_lo,
   output logic [dccm_pkg::DATA_WIDTH-1:0]   st_data_hi
);
   import dccm_pkg::*;

   logic [OFFSET_BITS-1:0]  offset_r;
   logic [2*BYTE_WIDTH-1:0] byteen_r;
   logic [DATA_WIDTH-1:0]   store_data_r;
   logic [DATA_WIDTH-1:0]   rdata_lo_r;
   logic [DATA_WIDTH-1:0]   rdata_hi_r;
   logic [2*DATA_WIDTH-1:0] fwd_data_r;
   logic [2*BYTE_WIDTH-1:0] fwd_byteen_r;
   logic [2*DATA_WIDTH-1:0] rdata_merged;
   logic [2*DATA_WIDTH-1:0] ld_shifted;
   logic [2*DATA_WIDTH-1:0] st_shifted;
   logic [2*DATA_WIDTH-1:0] st_merged;

   // per byte, take a where sel is set and b otherwise
   function automatic logic [2*DATA_WIDTH-1:0] byte_select(
      input logic [2*BYTE_WIDTH-1:0] sel,
      input logic [2*DATA_WIDTH-1:0] a,
      input logic [2*DATA_WIDTH-1:0] b
   );
      logic [2*DATA_WIDTH-1:0] res;
      for (int i = 0; i < 2*BYTE_WIDTH; i++) begin
         res[8*i +: 8] = sel[i] ? a[8*i +: 8] : b[8*i +: 8];
      end
      return res;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         ld_valid <= 1'b0;
         st_valid <= 1'b0;
      end else begin
         ld_valid <= pipe_m.valid & pipe_m.load;
         st_valid <= pipe_m.valid & pipe_m.store;
      end
   end

   // M to R payload, held while the stage is empty
   always_ff @(posedge clk) begin
      if (pipe_m.valid) begin
         offset_r     <= pipe_m.offset;
         byteen_r     <= pipe_m.byteen;
         store_data_r <= pipe_m.store_data;
         rdata_lo_r   <= mem_rd_data_lo;
         fwd_data_r   <= stbuf_fwd_data;
         fwd_byteen_r <= stbuf_fwd_byteen;
      end
      if (pipe_m.valid & pipe_m.dual) begin
         rdata_hi_r <= mem_rd_data_hi;                             // hi word only matters when dual
      end
   end

   // store buffer bytes are younger than the memory
   assign rdata_merged = byte_select(fwd_byteen_r, fwd_data_r, {rdata_hi_r, rdata_lo_r});

   // right-justify the load, upper bytes left as they fall
   assign ld_shifted = rdata_merged >> {offset_r, 3'b000};
   assign ld_data    = ld_shifted[DATA_WIDTH-1:0];

   // line the store bytes up with their position in hi:lo
   assign st_shifted = {{DATA_WIDTH{1'b0}}, store_data_r} << {offset_r, 3'b000};
   assign st_merged  = byte_select(byteen_r, st_shifted, {rdata_hi_r, rdata_lo_r});

   assign st_data_lo = st_merged[DATA_WIDTH-1:0];
   assign st_data_hi = st_merged[2*DATA_WIDTH-1:DATA_WIDTH];

endmodule

`default_nettype wire

/* hdl/lsu_dccm_ctl.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_dccm_ctl (
   input  logic                              clk,
   input  logic                              rst,
   input  dccm_pkg::lsu_pkt_t                lsu_pkt,
   input  logic                              stbuf_valid,
   input  dccm_pkg::stbuf_req_t              stbuf_req,
   output logic                              stbuf_ready,
   input  logic [2*dccm_pkg::DATA_WIDTH-1:0] stbuf_fwd_data,       // hi:lo
   input  logic [2*dccm_pkg::BYTE_WIDTH-1:0] stbuf_fwd_byteen,
   output dccm_pkg::mem_req_t                mem_req,
   input  logic [dccm_pkg::DATA_WIDTH-1:0]   mem_rd_data_lo,
   input  logic [dccm_pkg::DATA_WIDTH-1:0]   mem_rd_data_hi,
   output logic                              ld_valid,
   output logic [dccm_pkg::DATA_WIDTH-1:0]   ld_data,
   output logic                              st_valid,
   output logic [dccm_pkg::DATA_WIDTH-1:0]   st_data_lo,
   output logic [dccm_pkg::DATA_WIDTH-1:0]   st_data_hi
);
   import dccm_pkg::*;

   mem_req_t rd_req;                                               // D-stage read request
   pipe_m_t  pipe_m;                                               // access in M

   lsu_dccm_decode u_decode (
      .clk     (clk),
      .rst     (rst),
      .lsu_pkt (lsu_pkt),
      .rd_req  (rd_req),
      .pipe_m  (pipe_m)
   );

   lsu_dccm_port_arb u_port_arb (
      .rd_req      (rd_req),
      .stbuf_valid (stbuf_valid),
      .stbuf_req   (stbuf_req),
      .stbuf_ready (stbuf_ready),
      .mem_req     (mem_req)
   );

   lsu_dccm_result u_result (
      .clk              (clk),
      .rst              (rst),
      .pipe_m           (pipe_m),
      .mem_rd_data_lo   (mem_rd_data_lo),
      .mem_rd_data_hi   (mem_rd_data_hi),
      .stbuf_fwd_data   (stbuf_fwd_data),
      .stbuf_fwd_byteen (stbuf_fwd_byteen),
      .ld_valid         (ld_valid),
      .ld_data          (ld_data),
      .st_valid         (st_valid),
      .st_data_lo       (st_data_lo),
      .st_data_hi       (st_data_hi)
   );

endmodule

`default_nettype wire

/* verif/dccm_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module dccm_mem_model (
   input  logic                            clk,
   input  dccm_pkg::mem_req_t              mem_req,
   output logic [dccm_pkg::DATA_WIDTH-1:0] rd_data_lo,
   output logic [dccm_pkg::DATA_WIDTH-1:0] rd_data_hi
);
   import dccm_pkg::*;

   logic [DATA_WIDTH-1:0] mem [0:2**(DCCM_BITS-OFFSET_BITS)-1];   // one entry per word

   // every word starts distinct so a wrong row or bank shows up
   initial begin
      for (int i = 0; i < 2**(DCCM_BITS-OFFSET_BITS); i++) begin
         mem[i] = 32'hdcc0_0000 ^ (32'(i) * 32'h0001_0003);
      end
   end

   // both read ports registered, a read returns the word before a same-edge write
   always @(posedge clk) begin
      if (mem_req.rden) begin
         rd_data_lo <= mem[mem_req.rd_addr_lo.flat[DCCM_BITS-1:OFFSET_BITS]];
         rd_data_hi <= mem[mem_req.rd_addr_hi.flat[DCCM_BITS-1:OFFSET_BITS]];
      end
      if (mem_req.wren) begin
         mem[mem_req.wr_addr.flat[DCCM_BITS-1:OFFSET_BITS]] <= mem_req.wr_data;
      end
   end

endmodule

`default_nettype wire

/* verif/tb_lsu_dccm_ctl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_dccm_ctl;
   import dccm_pkg::*;

   logic                    clk;
   logic                    rst;
   lsu_pkt_t                lsu_pkt;
   logic                    stbuf_valid;
   stbuf_req_t              stbuf_req;
   logic                    stbuf_ready;
   logic [2*DATA_WIDTH-1:0] stbuf_fwd_data;
   logic [2*BYTE_WIDTH-1:0] stbuf_fwd_byteen;
   mem_req_t                mem_req;
   logic [DATA_WIDTH-1:0]   mem_rd_data_lo;
   logic [DATA_WIDTH-1:0]   mem_rd_data_hi;
   logic                    ld_valid;
   logic [DATA_WIDTH-1:0]   ld_data;
   logic                    st_valid;
   logic [DATA_WIDTH-1:0]   st_data_lo;
   logic [DATA_WIDTH-1:0]   st_data_hi;

   logic [DATA_WIDTH-1:0]   shadow [0:2**(DCCM_BITS-OFFSET_BITS)-1];   // expected memory words
   logic [31:0]             lcg_state = 32'd63;
   int                      cycle_cnt = 0;

   lsu_dccm_ctl u_dut (
      .clk              (clk),
      .rst              (rst),
      .lsu_pkt          (lsu_pkt),
      .stbuf_valid      (stbuf_valid),
      .stbuf_req        (stbuf_req),
      .stbuf_ready      (stbuf_ready),
      .stbuf_fwd_data   (stbuf_fwd_data),
      .stbuf_fwd_byteen (stbuf_fwd_byteen),
      .mem_req          (mem_req),
      .mem_rd_data_lo   (mem_rd_data_lo),
      .mem_rd_data_hi   (mem_rd_data_hi),
      .ld_valid         (ld_valid),
      .ld_data          (ld_data),
      .st_valid         (st_valid),
      .st_data_lo       (st_data_lo),
      .st_data_hi       (st_data_hi)
   );

   dccm_mem_model u_mem (
      .clk        (clk),
      .mem_req    (mem_req),
      .rd_data_lo (mem_rd_data_lo),
      .rd_data_hi (mem_rd_data_hi)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   // about 70 fill cycles and under 200 accesses of 3 cycles each
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= 2000) begin
         $display("timeout: tests still running after %0d cycles", cycle_cnt);
         abort_run();
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int size_bytes(input access_size_e size);
      case (size)
         size_half: return 2;
         size_word: return 4;
         default:   return 1;
      endcase
   endfunction

   // random word in 0x100..0x17c at the given offset whose next word is filled too
   function automatic logic [DCCM_BITS-1:0] window_addr(input logic [1:0] offset);
      logic [31:0] r;
      r = lcg_next();
      return 12'h100 + {5'd0, r[6:2], offset};
   endfunction

   function automatic lsu_pkt_t make_pkt(input logic is_load, input access_size_e size,
                                         input logic [DCCM_BITS-1:0] addr,
                                         input logic [31:0] sdata);
      lsu_pkt_t p;
      p.valid     = 1'b1;
      p.load      = is_load;
      p.store     = ~is_load;
      p.size      = size;
      p.addr.flat = addr;
      p.data      = sdata;
      return p;
   endfunction

   // overlay forwarded bytes on the two words and take 4 bytes from the start offset
   function automatic logic [31:0] expected_load(input logic [DCCM_BITS-1:0] addr,
                                                 input logic [7:0] fwd_be,
                                                 input logic [63:0] fwd_data);
      logic [63:0] words;
      int          off;
      off   = addr[1:0];
      words = {shadow[addr[11:2] + 10'd1], shadow[addr[11:2]]};
      for (int i = 0; i < 8; i++) begin
         if (fwd_be[i]) words[8*i +: 8] = fwd_data[8*i +: 8];
      end
      return words[8*off +: 32];
   endfunction

   function automatic logic [63:0] expected_store(input logic [DCCM_BITS-1:0] addr,
                                                  input access_size_e size,
                                                  input logic [31:0] sdata);
      logic [63:0] words;
      int          off;
      off   = addr[1:0];
      words = {shadow[addr[11:2] + 10'd1], shadow[addr[11:2]]};
      for (int i = 0; i < size_bytes(size); i++) begin
         words[8*(off+i) +: 8] = sdata[8*i +: 8];
      end
      return words;
   endfunction

   task automatic drive_stbuf(input logic [DCCM_BITS-1:0] addr, input logic [31:0] data);
      stbuf_valid         <= 1'b1;
      stbuf_req.addr.flat <= {addr[11:2], 2'b00};
      stbuf_req.data      <= data;
   endtask

   task automatic stbuf_write(input logic [DCCM_BITS-1:0] addr, input logic [31:0] data);
      @(posedge clk);
      drive_stbuf(addr, data);
      @(negedge clk);
      while (!stbuf_ready) @(negedge clk);
      @(posedge clk);                                              // accepted on this edge
      stbuf_valid <= 1'b0;
      shadow[addr[11:2]] = data;
   endtask

   // packet in D, forwarding in M, result sampled in R
   task automatic run_access(input logic is_load, input access_size_e size,
                             input logic [DCCM_BITS-1:0] addr, input logic [31:0] sdata,
                             input logic [7:0] fwd_be, input logic [63:0] fwd_data,
                             output logic rden_d, output logic [31:0] res_lo,
                             output logic [31:0] res_hi);
      @(posedge clk);
      lsu_pkt <= make_pkt(is_load, size, addr, sdata);
      @(negedge clk);
      rden_d = mem_req.rden;
      @(posedge clk);
      lsu_pkt          <= '0;
      stbuf_fwd_data   <= fwd_data;
      stbuf_fwd_byteen <= fwd_be;
      @(negedge clk);
      assert (!ld_valid && !st_valid) else begin
         $display("error: ld_valid = %h, st_valid = %h one cycle after D, expected 0",
                  ld_valid, st_valid);
         abort_run();
      end
      @(posedge clk);
      stbuf_fwd_byteen <= '0;
      @(negedge clk);
      assert (is_load ? (ld_valid && !st_valid) : (st_valid && !ld_valid)) else begin
         $display("error: ld_valid = %h, st_valid = %h two cycles after D, load = %h",
                  ld_valid, st_valid, is_load);
         abort_run();
      end
      res_lo = is_load ? ld_data : st_data_lo;
      res_hi = st_data_hi;
   endtask

   task automatic check_load(input access_size_e size, input logic [DCCM_BITS-1:0] addr,
                             input logic [7:0] fwd_be, input logic [63:0] fwd_data);
      logic        rden_d;
      logic [31:0] got;
      logic [31:0] unused_hi;
      logic [31:0] exp;
      logic [31:0] mask;
      int          nbytes;
      nbytes = size_bytes(size);
      exp    = expected_load(addr, fwd_be, fwd_data);
      mask   = 32'hffff_ffff;
      // upper word is stale unless the load crosses into it
      if (int'(addr[1:0]) + nbytes <= 4 && nbytes < 4) begin
         mask = (32'd1 << (8 * nbytes)) - 32'd1;
      end
      run_access(1'b1, size, addr, 32'h0, fwd_be, fwd_data, rden_d, got, unused_hi);
      assert (rden_d) else begin
         $display("error: mem_req.rden = %h in load D cycle, expected 1", rden_d);
         abort_run();
      end
      assert ((got & mask) == (exp & mask)) else begin
         $display("error: ld_data = %h, expected %h, mask %h, addr %h", got, exp, mask, addr);
         abort_run();
      end
   endtask

   task automatic check_store(input access_size_e size, input logic [DCCM_BITS-1:0] addr,
                              input logic [31:0] sdata);
      logic        rden_d;
      logic [31:0] got_lo;
      logic [31:0] got_hi;
      logic [63:0] exp;
      logic        aligned_word;
      exp          = expected_store(addr, size, sdata);
      aligned_word = (size == size_word) && (addr[1:0] == 2'd0);
      run_access(1'b0, size, addr, sdata, 8'h00, 64'h0, rden_d, got_lo, got_hi);
      assert (rden_d == !aligned_word) else begin
         $display("error: mem_req.rden = %h in store D cycle, expected %h", rden_d, !aligned_word);
         abort_run();
      end
      assert (got_lo == exp[31:0]) else begin
         $display("error: st_data_lo = %h, expected %h, addr %h", got_lo, exp[31:0], addr);
         abort_run();
      end
      if (int'(addr[1:0]) + size_bytes(size) > 4) begin
         assert (got_hi == exp[63:32]) else begin
            $display("error: st_data_hi = %h, expected %h, addr %h", got_hi, exp[63:32], addr);
            abort_run();
         end
      end
   endtask

   task automatic test_loads();
      for (int i = 0; i < 6; i++) begin
         check_load(size_word, window_addr(2'd0), 8'h00, 64'h0);
      end
      for (int i = 0; i < 4; i++) begin
         check_load(size_half, window_addr(2'd3), 8'h00, 64'h0);   // crosses into next word
         check_load(size_word, window_addr(2'd2), 8'h00, 64'h0);
         check_load(size_byte, window_addr(2'(i)), 8'h00, 64'h0);
      end
   endtask

   task automatic test_forwarding();
      logic [31:0] r;
      for (int i = 0; i < 8; i++) begin
         r = lcg_next();
         check_load(size_word, window_addr(r[9:8]), r[7:0], {lcg_next(), lcg_next()});
      end
   endtask

   task automatic test_store_merge();
      for (int off = 0; off < 4; off++) begin
         check_store(size_byte, window_addr(2'(off)), lcg_next());
         check_store(size_half, window_addr(2'(off)), lcg_next());
      end
      check_store(size_word, window_addr(2'd0), lcg_next());        // no read needed
      check_store(size_word, window_addr(2'd2), lcg_next());
   endtask

   task automatic test_arbitration();
      logic [DCCM_BITS-1:0] rd_addr;
      logic [DCCM_BITS-1:0] wr_addr;
      logic [31:0]          wr_data;
      logic [31:0]          exp_ld;
      wr_addr = window_addr(2'd0);
      wr_data = lcg_next();
      @(posedge clk);
      drive_stbuf(wr_addr, wr_data);
      @(negedge clk);
      assert (stbuf_ready && mem_req.wren) else begin
         $display("error: stbuf_ready = %h, wren = %h with idle pipe", stbuf_ready, mem_req.wren);
         abort_run();
      end
      @(posedge clk);
      stbuf_valid <= 1'b0;
      shadow[wr_addr[11:2]] = wr_data;
      rd_addr = window_addr(2'd0);
      wr_addr = rd_addr ^ 12'h010;                                 // same bank in another row
      wr_data = lcg_next();
      exp_ld  = shadow[rd_addr[11:2]];
      @(posedge clk);
      lsu_pkt <= make_pkt(1'b1, size_word, rd_addr, 32'h0);
      drive_stbuf(wr_addr, wr_data);
      @(negedge clk);
      assert (!stbuf_ready && !mem_req.wren) else begin
         $display("error: stbuf_ready = %h, wren = %h with a read on the same bank",
                  stbuf_ready, mem_req.wren);
         abort_run();
      end
      @(posedge clk);
      lsu_pkt <= '0;
      @(negedge clk);
      assert (stbuf_ready && mem_req.wren) else begin
         $display("error: stbuf_ready = %h, wren = %h after the read left D",
                  stbuf_ready, mem_req.wren);
         abort_run();
      end
      @(posedge clk);
      stbuf_valid <= 1'b0;
      shadow[wr_addr[11:2]] = wr_data;
      @(negedge clk);
      assert (ld_valid && ld_data == exp_ld) else begin
         $display("error: ld_data = %h, expected %h, ld_valid = %h", ld_data, exp_ld, ld_valid);
         abort_run();
      end
      check_load(size_word, wr_addr, 8'h00, 64'h0);                // sees the new word
   endtask

   initial begin
      rst              = 1'b1;
      lsu_pkt          = '0;
      stbuf_valid      = 1'b0;
      stbuf_req        = '0;
      stbuf_fwd_data   = '0;
      stbuf_fwd_byteen = '0;
      @(posedge clk);
      lsu_pkt <= make_pkt(1'b1, size_word, 12'h100, 32'h0);       // valid load held in reset
      repeat (7) @(posedge clk);
      rst     <= 1'b0;
      lsu_pkt <= '0;
      @(negedge clk);
      assert (!ld_valid && !st_valid && !u_dut.pipe_m.valid && !mem_req.rden && !mem_req.wren)
      else begin
         $display("error: ld_valid = %h, st_valid = %h, pipe_m.valid = %h after reset",
                  ld_valid, st_valid, u_dut.pipe_m.valid);
         $display("error: rden = %h, wren = %h after reset", mem_req.rden, mem_req.wren);
         abort_run();
      end
      for (int w = 64; w < 98; w++) begin                          // fill the test window
         stbuf_write(12'(w * 4), lcg_next());
      end
      test_loads();
      test_forwarding();
      test_store_merge();
      test_arbitration();
      @(posedge clk);
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
hdl/dccm_pkg.sv
hdl/lsu_dccm_decode.sv
hdl/lsu_dccm_port_arb.sv
hdl/lsu_dccm_result.sv
hdl/lsu_dccm_ctl.sv
verif/dccm_mem_model.sv
verif/tb_lsu_dccm_ctl.sv

/* Bender.yml */
package:
  name: lsu_dccm_ctl

sources:
  - files:
      - hdl/dccm_pkg.sv
      - hdl/lsu_dccm_decode.sv
      - hdl/lsu_dccm_port_arb.sv
      - hdl/lsu_dccm_result.sv
      - hdl/lsu_dccm_ctl.sv
  - target: test
    files:
      - verif/dccm_mem_model.sv
      - verif/tb_lsu_dccm_ctl.sv
